// ==== all.f ====
hw/commit_pkg.sv
hw/execute_commit_reg.sv
hw/commit_stage.sv
hw/trap_unit.sv
hw/branch_predictor.sv
hw/commit_top.sv
sim/tb_clock.sv
sim/commit_tb.sv

// ==== build.sh ====
#!/bin/sh
# Builds the commit testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module commit_tb -f all.f -o Vcommit_tb

# A $fatal exits non-zero, which set -e turns into a failing status
out=$(./obj_dir/Vcommit_tb)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1

// ==== sim/commit_tb.sv ====
`timescale 1ns/100ps

module commit_tb;

  localparam int RAND_BRANCHES = 200;
  localparam int DIRECTED_TXNS = 80;
  localparam int WATCHDOG_CYCLES = (RAND_BRANCHES + DIRECTED_TXNS) * 10 + 100;

  logic CLK;
  logic nRST;
  logic halt;
  logic exec_valid;
  commit_pkg::exec_commit_t exec_result;
  logic commit_stall;
  logic intr_pending;
  commit_pkg::pc_t lookup_pc;
  logic predict_taken;
  logic mispredict;
  logic redirect_valid;
  commit_pkg::pc_t redirect_pc;
  commit_pkg::pc_t mepc;
  commit_pkg::cause_t mcause;
  commit_pkg::word_t mtval;

  // Reference state built from the timing rules
  logic m_valid;
  commit_pkg::exec_commit_t m_slot;
  commit_pkg::pc_t m_last_pc;
  logic e_redirect;
  commit_pkg::pc_t e_redirect_pc;
  commit_pkg::pc_t e_mepc;
  commit_pkg::cause_t e_mcause;
  commit_pkg::word_t e_mtval;
  commit_pkg::counter_t ref_table [commit_pkg::BP_ENTRIES];
  logic m_fire;
  logic m_trap;
  logic m_train;
  logic e_mispredict;
  logic [63:0] m_rank;
  commit_pkg::pc_t m_epc;
  logic [31:0] rng_state;
  int errors;

  tb_clock u_clock (.CLK(CLK), .nRST(nRST));

  commit_top dut (
    .CLK(CLK), .nRST(nRST), .halt(halt), .exec_valid(exec_valid),
    .exec_result(exec_result), .commit_stall(commit_stall), .intr_pending(intr_pending),
    .lookup_pc(lookup_pc), .predict_taken(predict_taken), .mispredict(mispredict),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .mepc(mepc),
    .mcause(mcause), .mtval(mtval)
  );

  // Jump or branch targets off a word boundary count as misaligned fetch
  function automatic logic bad_target(input commit_pkg::exec_commit_t r);
    return r.mal_insn | (r.jump_instr && r.jump_addr[1:0] != 2'b00) |
           (r.branch_instr && r.br_resolved_addr[1:0] != 2'b00);
  endfunction

  function automatic logic sync_exc(input commit_pkg::exec_commit_t r);
    return r.breakpoint | bad_target(r) | r.illegal_opcode | r.invalid_csr |
           r.ecall_insn | (r.mal_addr & (r.dren | r.dwen));
  endfunction

  // Highest ranked cause in the upper word, trap value in the lower word
  function automatic logic [63:0] ranked_trap(input commit_pkg::exec_commit_t r, input logic intr);
    if (intr && r.intr_seen) return {commit_pkg::CAUSE_EXT_INTR, 32'h0};
    if (r.breakpoint) return {commit_pkg::CAUSE_BREAKPOINT, 32'h0};
    if (bad_target(r)) return {commit_pkg::CAUSE_MAL_INSN, r.pc};
    if (r.illegal_opcode || r.invalid_csr) return {commit_pkg::CAUSE_ILLEGAL, 32'h0};
    if (r.ecall_insn) return {commit_pkg::CAUSE_ECALL_M, 32'h0};
    if (r.dren && r.mal_addr) return {commit_pkg::CAUSE_MAL_LOAD, r.memory_addr};
    return {commit_pkg::CAUSE_MAL_STORE, r.memory_addr};
  endfunction

  assign m_fire = m_valid && !commit_stall;
  assign m_trap = sync_exc(m_slot) || (intr_pending && m_slot.intr_seen);
  assign m_rank = ranked_trap(m_slot, intr_pending);
  assign m_epc = (m_slot.opcode != 7'd0) ? m_slot.pc : m_last_pc;
  assign m_train = m_fire && m_slot.branch_instr && !sync_exc(m_slot);
  assign e_mispredict = m_train && (m_slot.branch_taken != m_slot.prediction);

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      m_valid <= 1'b0;
      m_last_pc <= '0;
      e_redirect <= 1'b0;
      e_redirect_pc <= '0;
      e_mepc <= '0;
      e_mcause <= '0;
      e_mtval <= '0;
      for (int i = 0; i < commit_pkg::BP_ENTRIES; i++) ref_table[i] <= 2'b01;
    end else begin
      // A slot committing during the redirect pulse is thrown away
      if (m_fire && !e_redirect && m_trap) begin
        e_redirect <= 1'b1;
        e_redirect_pc <= commit_pkg::TRAP_VECTOR;
        e_mepc <= m_epc;
        e_mcause <= m_rank[63:32];
        e_mtval <= m_rank[31:0];
      end else if (m_fire && !e_redirect && m_slot.ret_insn) begin
        e_redirect <= 1'b1;
        e_redirect_pc <= e_mepc;
      end else begin
        e_redirect <= 1'b0;
      end
      if (halt) m_last_pc <= '0;
      else if (m_fire && m_slot.opcode != 7'd0) m_last_pc <= m_slot.pc;
      if (m_train) begin
        if (m_slot.branch_taken && ref_table[m_slot.pc[7:2]] != 2'b11)
          ref_table[m_slot.pc[7:2]] <= ref_table[m_slot.pc[7:2]] + 2'b01;
        else if (!m_slot.branch_taken && ref_table[m_slot.pc[7:2]] != 2'b00)
          ref_table[m_slot.pc[7:2]] <= ref_table[m_slot.pc[7:2]] - 2'b01;
      end
      if (e_redirect) m_valid <= 1'b0;
      else if (!commit_stall) m_valid <= exec_valid;
      if (exec_valid && !commit_stall) m_slot <= exec_result;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  a_redirect: assert property (@(posedge CLK) disable iff (!nRST) redirect_valid == e_redirect)
    else report_mismatch("redirect_valid", $sampled(redirect_valid), $sampled(e_redirect));
  a_redirect_pc: assert property (@(posedge CLK) disable iff (!nRST)
    redirect_valid |-> redirect_pc == e_redirect_pc)
    else report_mismatch("redirect_pc", $sampled(redirect_pc), $sampled(e_redirect_pc));
  a_mepc: assert property (@(posedge CLK) disable iff (!nRST) mepc == e_mepc)
    else report_mismatch("mepc", $sampled(mepc), $sampled(e_mepc));
  a_mcause: assert property (@(posedge CLK) disable iff (!nRST) mcause == e_mcause)
    else report_mismatch("mcause", $sampled(mcause), $sampled(e_mcause));
  a_mtval: assert property (@(posedge CLK) disable iff (!nRST) mtval == e_mtval)
    else report_mismatch("mtval", $sampled(mtval), $sampled(e_mtval));
  a_mispredict: assert property (@(posedge CLK) disable iff (!nRST) mispredict == e_mispredict)
    else report_mismatch("mispredict", $sampled(mispredict), $sampled(e_mispredict));
  a_predict: assert property (@(posedge CLK) disable iff (!nRST)
    predict_taken == ref_table[lookup_pc[7:2]][1])
    else report_mismatch("predict_taken", $sampled(predict_taken),
                         $sampled(ref_table[lookup_pc[7:2]][1]));

  // Marsaglia xorshift with the 13, 17, 5 shift triple
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bits pick breakpoint, mal_insn, illegal, csr, ecall, load, store, bad branch target
  function automatic commit_pkg::exec_commit_t make_record(input commit_pkg::pc_t pc,
                                                          input logic [7:0] cls,
                                                          input commit_pkg::word_t addr);
    commit_pkg::exec_commit_t r;
    r = '0;
    r.pc = pc;
    r.opcode = 7'h13;
    r.memory_addr = addr;
    r.breakpoint = cls[0];
    r.mal_insn = cls[1];
    r.illegal_opcode = cls[2];
    r.invalid_csr = cls[3];
    r.ecall_insn = cls[4];
    r.dren = cls[5];
    r.dwen = cls[6];
    r.mal_addr = cls[5] | cls[6];
    r.branch_instr = cls[7];
    r.br_resolved_addr = cls[7] ? pc + 32'd6 : '0;
    return r;
  endfunction

  // Strobe one record, optionally stall it in the slot, then let the redirect drain
  task automatic issue(input commit_pkg::exec_commit_t r, input logic intr, input int stall_len);
    @(posedge CLK);
    exec_valid <= 1'b1;
    exec_result <= r;
    intr_pending <= intr;
    @(posedge CLK);
    exec_valid <= 1'b0;
    if (stall_len > 0) begin
      commit_stall <= 1'b1;
      repeat (stall_len) @(posedge CLK);
      commit_stall <= 1'b0;
    end
    @(posedge CLK);
    intr_pending <= 1'b0;
    repeat (2) @(posedge CLK);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Watchdog expired before the stimulus finished");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    logic [31:0] v;
    commit_pkg::exec_commit_t r;
    errors = 0;
    rng_state = 32'hfcb6_9647;
    halt = 1'b0;
    exec_valid = 1'b0;
    exec_result = '0;
    commit_stall = 1'b0;
    intr_pending = 1'b0;
    lookup_pc = '0;
    @(posedge nRST);
    // Sweep every table entry while the counters are still weakly not taken
    for (int i = 0; i < commit_pkg::BP_ENTRIES; i++) begin
      @(posedge CLK);
      lookup_pc <= i << 2;
    end
    for (int k = 0; k < 8; k++) issue(make_record(32'h400 + (k << 4), 8'(1 << k), 32'h777), 0, 0);
    r = make_record(32'h480, 8'h00, '0);
    r.intr_seen = 1'b1;
    issue(r, 1'b1, 0);
    r = make_record(32'h484, 8'h00, '0);
    r.jump_instr = 1'b1;
    r.jump_addr = 32'h0000_0202;
    issue(r, 1'b0, 0);
    for (int k = 0; k < 40; k++) begin
      rng_state = xorshift32(rng_state);
      v = rng_state;
      r = make_record({20'h0, v[11:4], 4'h0}, v[19:12], {v[31:20], 20'h3});
      r.intr_seen = v[20];
      issue(r, v[21], 0);
    end
    // A bubble taking an interrupt returns to the last retired PC, then zero after halt
    issue(make_record(32'h2000, 8'h00, '0), 0, 0);
    r = '0;
    r.pc = 32'h3333;
    r.intr_seen = 1'b1;
    issue(r, 1'b1, 0);
    @(posedge CLK);
    halt <= 1'b1;
    @(posedge CLK);
    halt <= 1'b0;
    issue(r, 1'b1, 0);
    r = '0;
    r.pc = 32'h2100;
    r.opcode = 7'h73;
    r.ret_insn = 1'b1;
    issue(r, 1'b0, 0);
    for (int s = 1; s < 5; s++) issue(make_record(32'h600 + (s << 2), 8'h10, '0), 0, s);
    // The same return now goes back to the last stalled ecall
    issue(r, 1'b0, 0);
    // In a run of three back to back strobes the second lands in the redirect pulse
    // and the third is flushed
    @(posedge CLK);
    exec_valid <= 1'b1;
    exec_result <= make_record(32'h700, 8'h01, '0);
    @(posedge CLK);
    exec_result <= make_record(32'h704, 8'h04, '0);
    @(posedge CLK);
    exec_result <= make_record(32'h708, 8'h10, '0);
    @(posedge CLK);
    exec_valid <= 1'b0;
    repeat (4) @(posedge CLK);
    for (int k = 0; k < RAND_BRANCHES; k++) begin
      rng_state = xorshift32(rng_state);
      v = rng_state;
      r = make_record(32'h1000 | {v[4:2], 2'b00}, 8'h00, '0);
      r.opcode = 7'h63;
      r.branch_instr = 1'b1;
      r.br_resolved_addr = 32'h1800;
      r.branch_taken = v[8];
      r.prediction = v[9];
      @(posedge CLK);
      exec_valid <= 1'b1;
      exec_result <= r;
      lookup_pc <= r.pc;
      @(posedge CLK);
      exec_valid <= 1'b0;
      commit_stall <= (v[13:12] == 2'b00);
      repeat (v[15:14]) @(posedge CLK);
      commit_stall <= 1'b0;
      repeat (v[11:10] + 1) @(posedge CLK);
    end
    repeat (4) @(posedge CLK);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic CLK,
  output logic nRST
);

  // 20 ns period, reset held low over the first five rising edges
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule

// ==== hw/commit_top.sv ====
`timescale 1ns/100ps

module commit_top (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     halt,
  input  logic                     exec_valid,
  input  commit_pkg::exec_commit_t exec_result,
  input  logic                     commit_stall,
  input  logic                     intr_pending,
  input  commit_pkg::pc_t          lookup_pc,
  output logic                     predict_taken,
  output logic                     mispredict,
  output logic                     redirect_valid,
  output commit_pkg::pc_t          redirect_pc,
  output commit_pkg::pc_t          mepc,
  output commit_pkg::cause_t       mcause,
  output commit_pkg::word_t        mtval
);

  // Between the pipeline register and the commit stage
  logic                     slot_valid;
  commit_pkg::exec_commit_t slot;
  // Commit results toward the trap unit and the predictor
  logic                     commit_fire;
  commit_pkg::exc_flags_t   flags;
  commit_pkg::bp_update_t   bp_update;

  // The redirect pulse doubles as the pipeline flush
  execute_commit_reg u_execute_commit_reg (
    .CLK(CLK), .nRST(nRST), .exec_valid(exec_valid), .exec_result(exec_result),
    .commit_stall(commit_stall), .flush(redirect_valid), .slot_valid(slot_valid),
    .slot(slot)
  );

  commit_stage u_commit_stage (
    .CLK(CLK), .nRST(nRST), .halt(halt), .commit_stall(commit_stall),
    .slot_valid(slot_valid), .slot(slot), .commit_fire(commit_fire), .flags(flags),
    .bp_update(bp_update), .mispredict(mispredict)
  );

  trap_unit u_trap_unit (
    .CLK(CLK), .nRST(nRST), .commit_fire(commit_fire), .flags(flags),
    .intr_pending(intr_pending), .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc), .mepc(mepc), .mcause(mcause), .mtval(mtval)
  );

  branch_predictor u_branch_predictor (
    .CLK(CLK), .nRST(nRST), .lookup_pc(lookup_pc), .predict_taken(predict_taken),
    .bp_update(bp_update)
  );

endmodule

// ==== hw/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
  input  logic                   CLK,
  input  logic                   nRST,
  input  commit_pkg::pc_t        lookup_pc,
  output logic                   predict_taken,
  input  commit_pkg::bp_update_t bp_update
);

  // Bimodal table of two bit saturating counters
  commit_pkg::counter_t table_q [commit_pkg::BP_ENTRIES];

  commit_pkg::bp_index_t lookup_idx;
  commit_pkg::bp_index_t update_idx;
  commit_pkg::counter_t cur_count;
  commit_pkg::counter_t next_count;

  // Word aligned PCs, so the two lowest bits carry no information
  function automatic commit_pkg::bp_index_t pc_index(input commit_pkg::pc_t pc);
    return pc[commit_pkg::BP_INDEX_LSB +: commit_pkg::BP_INDEX_W];
  endfunction

  // Step one count toward the resolved direction and stop at the ends
  function automatic commit_pkg::counter_t sat_step(
    input commit_pkg::counter_t count,
    input logic                 taken
  );
    commit_pkg::counter_t result;
    result = count;
    if (taken && count != 2'b11) begin
      result = count + 2'b01;
    end else if (!taken && count != 2'b00) begin
      result = count - 2'b01;
    end
    return result;
  endfunction

  assign lookup_idx = pc_index(lookup_pc);
  assign update_idx = pc_index(bp_update.pc);

  // The upper bit of the counter is the predicted direction
  // Lookups are purely combinational, a write is seen one cycle later
  assign predict_taken = table_q[lookup_idx][1];

  assign cur_count = table_q[update_idx];
  assign next_count = sat_step(cur_count, bp_update.taken);

  // Every counter starts weakly not taken after reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < commit_pkg::BP_ENTRIES; i++) begin
        table_q[i] <= commit_pkg::COUNTER_INIT;
      end
    end else if (bp_update.valid) begin
      table_q[update_idx] <= next_count;
    end
  end

  // A counter must move by at most one step per update
  // The compare runs one bit wider so that a count wrapping around at
  // either end is not mistaken for a single step
  a_saturating_step: assert property (
    @(posedge CLK) disable iff (!nRST)
    bp_update.valid |=>
      ((table_q[$past(update_idx)] == $past(cur_count)) ||
       ({1'b0, table_q[$past(update_idx)]} == {1'b0, $past(cur_count)} + 3'd1) ||
       ({1'b0, table_q[$past(update_idx)]} + 3'd1 == {1'b0, $past(cur_count)}))
  ) else $error("predictor counter jumped");

endmodule

// ==== hw/trap_unit.sv ====
`timescale 1ns/100ps

module trap_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   commit_fire,
  input  commit_pkg::exc_flags_t flags,
  input  logic                   intr_pending,
  output logic                   redirect_valid,
  output commit_pkg::pc_t        redirect_pc,
  output commit_pkg::pc_t        mepc,
  output commit_pkg::cause_t     mcause,
  output commit_pkg::word_t      mtval
);

  commit_pkg::trap_state_t state;
  // Interrupt accepted on this slot
  logic intr_req;
  logic exc_req;
  logic trap_req;
  logic ret_req;
  // Ranked cause and matching trap value of the committing slot
  commit_pkg::cause_t trap_cause;
  commit_pkg::word_t trap_tval;

  assign intr_req = flags.intr_taken & intr_pending;
  assign exc_req = flags.mal_l | flags.mal_s | flags.breakpoint | flags.env_m |
                   flags.illegal_insn | flags.mal_insn;

  // Requests are ignored during the redirect pulse since that slot is
  // about to be flushed anyway
  assign trap_req = commit_fire & (state == commit_pkg::IDLE) & (intr_req | exc_req);
  // A return counts only when nothing of higher rank happens with it
  assign ret_req = commit_fire & (state == commit_pkg::IDLE) & flags.ret & ~trap_req;

  // Priority order, highest first
  always_comb begin
    trap_cause = commit_pkg::CAUSE_MAL_STORE;
    trap_tval = flags.badaddr_d;
    if (intr_req) begin
      trap_cause = commit_pkg::CAUSE_EXT_INTR;
      trap_tval = '0;
    end else if (flags.breakpoint) begin
      trap_cause = commit_pkg::CAUSE_BREAKPOINT;
      trap_tval = '0;
    end else if (flags.mal_insn) begin
      trap_cause = commit_pkg::CAUSE_MAL_INSN;
      trap_tval = flags.badaddr_i;
    end else if (flags.illegal_insn) begin
      trap_cause = commit_pkg::CAUSE_ILLEGAL;
      trap_tval = '0;
    end else if (flags.env_m) begin
      trap_cause = commit_pkg::CAUSE_ECALL_M;
      trap_tval = '0;
    end else if (flags.mal_l) begin
      trap_cause = commit_pkg::CAUSE_MAL_LOAD;
    end
  end

  // Trap CSRs and redirect FSM
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= commit_pkg::IDLE;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
    end else if (trap_req) begin
      state <= commit_pkg::REDIRECT;
      mepc <= flags.epc;
      mcause <= trap_cause;
      mtval <= trap_tval;
    end else if (ret_req) begin
      state <= commit_pkg::REDIRECT;
    end else begin
      // REDIRECT lasts exactly one cycle
      state <= commit_pkg::IDLE;
    end
  end

  // Target of the pending redirect, qualified by redirect_valid
  always_ff @(posedge CLK) begin
    if (trap_req) begin
      redirect_pc <= commit_pkg::TRAP_VECTOR;
    end else if (ret_req) begin
      // mret goes back to the address saved by the last trap
      redirect_pc <= mepc;
    end
  end

  assign redirect_valid = (state == commit_pkg::REDIRECT);

  // Back to back redirects would flush a slot that already saw a redirect
  a_single_redirect: assert property (
    @(posedge CLK) disable iff (!nRST)
    redirect_valid |=> !redirect_valid
  ) else $error("redirect lasted two cycles");

endmodule

// ==== hw/commit_stage.sv ====
`timescale 1ns/100ps

module commit_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     halt,
  input  logic                     commit_stall,
  input  logic                     slot_valid,
  input  commit_pkg::exec_commit_t slot,
  output logic                     commit_fire,
  output commit_pkg::exc_flags_t   flags,
  output commit_pkg::bp_update_t   bp_update,
  output logic                     mispredict
);

  // Set when the slot holds a real instruction and not a bubble
  logic valid_pc;
  // Last PC that actually committed, used as epc for bubbles
  commit_pkg::pc_t latest_valid_pc;
  // Control transfer targets that are not word aligned
  logic illegal_jaddr;
  logic illegal_braddr;
  // Any synchronous exception raised by the slot
  logic exc_raised;
  logic branch_commit;

  // The slot retires in any cycle where it is valid and not stalled
  assign commit_fire = slot_valid & ~commit_stall;

  assign valid_pc = (slot.opcode != commit_pkg::opcode_t'(0));

  // Jump and branch targets must sit on a word boundary since there is
  // no compressed instruction support
  assign illegal_jaddr = slot.jump_instr & (slot.jump_addr[1:0] != 2'b00);
  assign illegal_braddr = slot.branch_instr & (slot.br_resolved_addr[1:0] != 2'b00);

  // Memory faults only count for the access direction that was performed
  assign flags.mal_l = slot.dren & slot.mal_addr;
  assign flags.mal_s = slot.dwen & slot.mal_addr;
  assign flags.breakpoint = slot.breakpoint;
  assign flags.env_m = slot.ecall_insn;
  assign flags.ret = slot.ret_insn;
  // Either a bad opcode or an access to an unimplemented CSR
  assign flags.illegal_insn = slot.illegal_opcode | slot.invalid_csr;
  assign flags.mal_insn = slot.mal_insn | illegal_jaddr | illegal_braddr;
  assign flags.intr_taken = slot.intr_seen;

  // Faulting data address and faulting instruction address for mtval
  assign flags.badaddr_d = slot.memory_addr;
  assign flags.badaddr_i = slot.pc;

  // A bubble has no PC of its own, so an interrupt taken on a bubble
  // returns to the last instruction that made it through commit
  assign flags.epc = valid_pc ? slot.pc : latest_valid_pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      latest_valid_pc <= '0;
    end else if (halt) begin
      latest_valid_pc <= '0;
    end else if (commit_fire && valid_pc) begin
      latest_valid_pc <= slot.pc;
    end
  end

  // Interrupts are not counted here, the trap unit qualifies them with
  // the pending level
  assign exc_raised = flags.mal_l | flags.mal_s | flags.breakpoint | flags.env_m |
                      flags.illegal_insn | flags.mal_insn;

  // Only branches that really retire train the predictor
  // A trapping branch is discarded and must leave the counters alone
  assign branch_commit = commit_fire & slot.branch_instr & ~exc_raised;

  // The table is indexed by the branch's own PC, the same address the
  // fetch side uses for its lookups
  assign bp_update.valid = branch_commit;
  assign bp_update.pc = slot.pc;
  assign bp_update.taken = slot.branch_taken;

  // Resolved direction disagrees with what fetch assumed
  assign mispredict = branch_commit & (slot.branch_taken != slot.prediction);

  // Training must never happen for a slot that did not retire
  a_update_needs_commit: assert property (
    @(posedge CLK) disable iff (!nRST)
    bp_update.valid |-> commit_fire
  ) else $error("predictor update without commit");

endmodule

// ==== hw/execute_commit_reg.sv ====
`timescale 1ns/100ps

module execute_commit_reg (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     exec_valid,
  input  commit_pkg::exec_commit_t exec_result,
  input  logic                     commit_stall,
  input  logic                     flush,
  output logic                     slot_valid,
  output commit_pkg::exec_commit_t slot
);

  // A new record may enter only when the slot is not frozen
  logic capture;

  assign capture = exec_valid & ~commit_stall;

  // Valid bit of the slot
  // Flush wins over everything so a record arriving during a redirect
  // pulse is dropped at the same edge that empties the slot
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      slot_valid <= 1'b0;
    end else if (flush) begin
      slot_valid <= 1'b0;
    end else if (!commit_stall) begin
      // Without a new strobe the committed record simply leaves the slot
      slot_valid <= exec_valid;
    end
  end

  // Payload of the slot
  // It only moves with a capture, so a stalled record stays in place
  // until the stall level falls
  always_ff @(posedge CLK) begin
    if (capture) begin
      slot <= exec_result;
    end
  end

  // A stalled valid slot must present the same record on the next cycle,
  // otherwise the commit stage would see a different instruction once
  // the stall releases
  a_slot_held_in_stall: assert property (
    @(posedge CLK) disable iff (!nRST)
    (slot_valid && commit_stall) |=> $stable(slot)
  ) else $error("commit slot changed while stalled");

endmodule

// ==== hw/commit_pkg.sv ====
package commit_pkg;

  // Machine word width for RV32
  localparam int XLEN = 32;
  localparam int OPCODE_W = 7;

  // The predictor table is indexed by pc bits 7 down to 2
  localparam int BP_INDEX_W = 6;
  localparam int BP_INDEX_LSB = 2;
  localparam int BP_ENTRIES = 1 << BP_INDEX_W;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] pc_t;
  // An opcode of zero marks a bubble in the commit slot
  typedef logic [OPCODE_W-1:0] opcode_t;
  // Bit 31 of mcause separates interrupts from synchronous exceptions
  typedef logic [XLEN-1:0] cause_t;
  typedef logic [BP_INDEX_W-1:0] bp_index_t;
  typedef logic [1:0] counter_t;

  // Counters start weakly not taken
  localparam counter_t COUNTER_INIT = 2'b01;

  // All traps go to one fixed handler since vectored mode is not supported
  localparam pc_t TRAP_VECTOR = 32'h0000_0100;

  localparam cause_t CAUSE_MAL_INSN = 32'd0;
  localparam cause_t CAUSE_ILLEGAL = 32'd2;
  localparam cause_t CAUSE_BREAKPOINT = 32'd3;
  localparam cause_t CAUSE_MAL_LOAD = 32'd4;
  localparam cause_t CAUSE_MAL_STORE = 32'd6;
  localparam cause_t CAUSE_ECALL_M = 32'd11;
  localparam cause_t CAUSE_EXT_INTR = 32'h8000_000b;

  // One executed instruction as handed over from the execute stage
  typedef struct packed {
    pc_t     pc;
    opcode_t opcode;
    word_t   memory_addr;
    logic    dren;
    logic    dwen;
    logic    mal_addr;
    logic    breakpoint;
    logic    ecall_insn;
    logic    ret_insn;
    logic    illegal_opcode;
    logic    invalid_csr;
    logic    mal_insn;
    logic    jump_instr;
    pc_t     jump_addr;
    logic    branch_instr;
    pc_t     br_resolved_addr;
    logic    branch_taken;
    logic    prediction;
    logic    intr_seen;
  } exec_commit_t;

  // Exception view of the committing slot as seen by the trap unit
  typedef struct packed {
    logic  mal_l;
    logic  mal_s;
    logic  breakpoint;
    logic  env_m;
    logic  ret;
    logic  illegal_insn;
    logic  mal_insn;
    logic  intr_taken;
    word_t badaddr_d;
    word_t badaddr_i;
    pc_t   epc;
  } exc_flags_t;

  typedef struct packed {
    logic valid;
    pc_t  pc;
    logic taken;
  } bp_update_t;

  typedef enum logic {
    IDLE,
    REDIRECT
  } trap_state_t;

endpackage
